/* verilog/serial_alu_macros.svh */
`ifndef SERIAL_ALU_MACROS_SVH
`define SERIAL_ALU_MACROS_SVH

`define SA_XLEN        32
`define SA_FIFO_DEPTH  4

// ------------------------------------------------------------------------
// APB register map (byte offsets)
// ------------------------------------------------------------------------
`define SA_REG_OPA     8'h00
`define SA_REG_OPB     8'h04
`define SA_REG_CMD     8'h08
`define SA_REG_STATUS  8'h0C
`define SA_REG_RVAL    8'h10
`define SA_REG_RINFO   8'h14

`endif

/* verilog/serial_alu_pkg.sv */
`default_nettype none

`include "serial_alu_macros.svh"

package serial_alu_pkg;

   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_SLT = 3'd2,                        // signed less-than, two passes
      OP_SLL = 3'd3,                        // shift left, two passes
      OP_BRK = 3'd4                         // 5..7 are illegal
   } op_e;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_INIT = 2'd1,
      ST_RUN  = 2'd2,
      ST_TRAP = 2'd3
   } seq_state_e;

   typedef enum logic [3:0] {
      CAUSE_NONE    = 4'd0,
      CAUSE_ILLEGAL = 4'd2,
      CAUSE_BREAK   = 4'd3
   } cause_e;

   typedef struct packed {
      op_e                 op;
      logic [3:0]          tag;
      logic [`SA_XLEN-1:0] opa;
      logic [`SA_XLEN-1:0] opb;
   } cmd_t;                                 // 71 bits

   typedef struct packed {
      logic [3:0]          tag;
      cause_e              cause;
      logic [`SA_XLEN-1:0] value;
   } result_t;                              // 40 bits

endpackage

`default_nettype wire

/* verilog/sync_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "serial_alu_macros.svh"

module sync_fifo #(
   parameter int WIDTH = 8
) (
   input  wire logic             i_clk,
   input  wire logic             i_rst,
   input  wire logic             i_push,
   input  wire logic [WIDTH-1:0] i_data,
   input  wire logic             i_ready,
   output logic      [WIDTH-1:0] o_data,
   output logic                  o_valid,
   output logic                  o_full,
   output logic      [2:0]       o_count
);

   localparam int         PTR_W     = $clog2(`SA_FIFO_DEPTH);
   localparam logic [2:0] DEPTH_CNT = 3'(`SA_FIFO_DEPTH);

   logic [WIDTH-1:0] mem [`SA_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [2:0]       count;
   logic             do_push;
   logic             do_pop;

   assign do_push = i_push & ~o_full;       // drop when full
   assign do_pop  = i_ready & o_valid;      // ignore when empty

   assign o_data  = mem[rd_ptr];
   assign o_valid = (count != 3'd0);
   assign o_full  = (count == DEPTH_CNT);
   assign o_count = count;

   always_ff @(posedge i_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= 3'd0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + PTR_W'(1);
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + PTR_W'(1);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 3'd1;
            2'b01:   count <= count - 3'd1;
            default: count <= count;        // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog/apb_cmd_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "serial_alu_macros.svh"

module apb_cmd_port (
   input  wire logic                    i_clk,
   input  wire logic                    i_rst,
   input  wire logic                    i_psel,
   input  wire logic                    i_penable,
   input  wire logic                    i_pwrite,
   input  wire logic [7:0]              i_paddr,
   input  wire logic [31:0]             i_pwdata,
   output logic      [31:0]             o_prdata,
   output logic                         o_pready,
   output logic                         o_pslverr,
   input  wire logic                    i_cmd_full,
   input  wire logic                    i_res_valid,
   input  wire serial_alu_pkg::result_t i_res,
   input  wire logic [2:0]              i_res_count,
   output logic                         o_cmd_push,
   output serial_alu_pkg::cmd_t         o_cmd,
   output logic                         o_res_pop
);
   import serial_alu_pkg::*;

   logic                access;
   logic                wr_en;
   logic                rd_en;
   logic                res_sel;
   logic [`SA_XLEN-1:0] opa_q;
   logic [`SA_XLEN-1:0] opb_q;

   assign access   = i_psel & i_penable;    // access phase only
   assign wr_en    = access & i_pwrite;
   assign rd_en    = access & ~i_pwrite;
   assign res_sel  = (i_paddr == `SA_REG_RVAL) | (i_paddr == `SA_REG_RINFO);
   assign o_pready = 1'b1;                  // no wait states

   assign o_cmd_push = wr_en & (i_paddr == `SA_REG_CMD) & ~i_cmd_full;
   assign o_res_pop  = rd_en & (i_paddr == `SA_REG_RINFO) & i_res_valid;

   assign o_pslverr = (wr_en & (i_paddr == `SA_REG_CMD) & i_cmd_full) |
                      (rd_en & res_sel & ~i_res_valid);

   // ------------------------------------------------------------------------
   // operand registers and command assembly
   // ------------------------------------------------------------------------
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         opa_q <= '0;
         opb_q <= '0;
      end else if (wr_en) begin
         if (i_paddr == `SA_REG_OPA) begin
            opa_q <= i_pwdata;
         end
         if (i_paddr == `SA_REG_OPB) begin
            opb_q <= i_pwdata;
         end
      end
   end

   always_comb begin
      o_cmd.op  = op_e'(i_pwdata[2:0]);     // illegal codes pass through
      o_cmd.tag = i_pwdata[7:4];
      o_cmd.opa = opa_q;
      o_cmd.opb = opb_q;
   end

   // ------------------------------------------------------------------------
   // read data mux
   // ------------------------------------------------------------------------
   always_comb begin
      o_prdata = '0;
      case (i_paddr)
         `SA_REG_STATUS: begin
            o_prdata[0]    = i_cmd_full;
            o_prdata[10:8] = i_res_count;
         end
         `SA_REG_RVAL: begin
            if (i_res_valid) begin
               o_prdata = i_res.value;      // peek, no pop
            end
         end
         `SA_REG_RINFO: begin
            if (i_res_valid) begin
               o_prdata = {24'd0, i_res.cause, i_res.tag};
            end
         end
         default: o_prdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* verilog/serial_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module serial_sequencer (
   input  wire logic                 i_clk,
   input  wire logic                 i_rst,
   input  wire logic                 i_cmd_valid,
   input  wire serial_alu_pkg::cmd_t i_cmd,
   input  wire logic                 i_res_full,
   output logic                      o_cmd_ready,
   output logic                      o_load,
   output serial_alu_pkg::op_e       o_op,
   output logic                      o_init,
   output logic                      o_run,
   output logic                      o_trap,
   output logic      [4:0]           o_cnt,
   output logic                      o_cnt_done,
   output logic                      o_stage_two
);
   import serial_alu_pkg::*;

   seq_state_e state_q;
   logic       held_q;                      // popped, not yet decoded
   logic       stage_two_q;
   logic [4:0] cnt_q;
   op_e        op_q;
   logic       two_stage_op;
   logic       trap_op;

   always_comb begin
      two_stage_op = (op_q == OP_SLT) || (op_q == OP_SLL);
      trap_op      = !(op_q inside {OP_ADD, OP_SUB, OP_SLT, OP_SLL});
   end

   // hold off popping while the result queue has no room
   assign o_cmd_ready = (state_q == ST_IDLE) & ~held_q & ~stage_two_q & ~i_res_full;
   assign o_load      = o_cmd_ready & i_cmd_valid;

   assign o_init      = (state_q == ST_INIT);
   assign o_run       = (state_q == ST_RUN);
   assign o_trap      = (state_q == ST_TRAP);
   assign o_cnt       = cnt_q;
   assign o_cnt_done  = (cnt_q == 5'd31) & (o_init | o_run);   // last bit of a pass
   assign o_stage_two = stage_two_q;
   assign o_op        = op_q;

   always_ff @(posedge i_clk) begin
      if (o_load) begin
         op_q <= i_cmd.op;
      end
   end

   // ------------------------------------------------------------------------
   // state machine and bit counter
   // ------------------------------------------------------------------------
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q     <= ST_IDLE;
         held_q      <= 1'b0;
         stage_two_q <= 1'b0;
         cnt_q       <= 5'd0;
      end else begin
         if (o_load) begin
            held_q <= 1'b1;
         end
         if (state_q != ST_IDLE) begin
            cnt_q <= cnt_q + 5'd1;          // wraps to 0 after a pass
         end
         case (state_q)
            ST_IDLE: begin
               if (stage_two_q) begin
                  state_q <= ST_RUN;        // second pass of SLT/SLL
               end else if (held_q && !i_res_full) begin
                  held_q <= 1'b0;
                  if (trap_op) begin
                     state_q <= ST_TRAP;
                  end else if (two_stage_op) begin
                     state_q <= ST_INIT;
                  end else begin
                     state_q <= ST_RUN;
                  end
               end
            end
            ST_INIT: begin
               if (o_cnt_done) begin
                  state_q     <= ST_IDLE;
                  stage_two_q <= 1'b1;
               end
            end
            ST_RUN: begin
               if (o_cnt_done) begin
                  state_q     <= ST_IDLE;
                  stage_two_q <= 1'b0;
               end
            end
            ST_TRAP: begin
               state_q <= ST_IDLE;          // single cycle
               cnt_q   <= 5'd0;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog/serial_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

`include "serial_alu_macros.svh"

module serial_datapath (
   input  wire logic                 i_clk,
   input  wire logic                 i_rst,
   input  wire logic                 i_load,
   input  wire serial_alu_pkg::cmd_t i_cmd,
   input  wire logic                 i_init,
   input  wire logic                 i_run,
   input  wire logic                 i_trap,
   input  wire logic [4:0]           i_cnt,
   input  wire logic                 i_cnt_done,
   input  wire logic                 i_stage_two,
   output logic                      o_res_valid,
   output serial_alu_pkg::result_t   o_res
);
   import serial_alu_pkg::*;

   localparam int XW = `SA_XLEN;

   logic [XW-1:0] opa_q;
   logic [XW-1:0] opb_q;
   logic [XW-1:0] res_q;
   op_e           op_q;
   logic [3:0]    tag_q;
   cause_e        cause_q;
   logic          carry_q;
   logic [4:0]    shamt_q;
   logic          slt_q;
   logic          invert_b;
   logic          a_bit;
   logic          b_bit;
   logic          sum_bit;
   logic          carry_out;
   logic          sll_hold;
   logic          res_bit;

   // ------------------------------------------------------------------------
   // serial adder and result bit select
   // ------------------------------------------------------------------------
   always_comb begin
      invert_b  = (op_q == OP_SUB) || (op_q == OP_SLT);
      a_bit     = opa_q[0];
      b_bit     = opb_q[0] ^ invert_b;
      sum_bit   = a_bit ^ b_bit ^ carry_q;
      carry_out = (a_bit & b_bit) | (carry_q & (a_bit ^ b_bit));
      sll_hold  = i_run && (op_q == OP_SLL) && (i_cnt < shamt_q);   // shifted-in zeros
      if (!i_stage_two) begin
         res_bit = sum_bit;
      end else if (op_q == OP_SLT) begin
         res_bit = (i_cnt == 5'd0) & slt_q;
      end else begin
         res_bit = sll_hold ? 1'b0 : a_bit;
      end
   end

   // operands rotate so they are intact again after a full INIT pass
   always_ff @(posedge i_clk) begin
      if (i_load) begin
         opa_q <= i_cmd.opa;
         opb_q <= i_cmd.opb;
         op_q  <= i_cmd.op;
         tag_q <= i_cmd.tag;
      end else if (i_init || i_run) begin
         if (!sll_hold) begin
            opa_q <= {opa_q[0], opa_q[XW-1:1]};
         end
         opb_q <= {opb_q[0], opb_q[XW-1:1]};
      end
      if (i_run) begin
         res_q <= {res_bit, res_q[XW-1:1]};   // lsb first
      end else if (i_trap) begin
         res_q <= '0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_res_valid <= 1'b0;
         carry_q     <= 1'b0;
         shamt_q     <= 5'd0;
         slt_q       <= 1'b0;
         cause_q     <= CAUSE_NONE;
      end else begin
         o_res_valid <= (i_run & i_cnt_done) | i_trap;
         if (i_load) begin
            carry_q <= (i_cmd.op == OP_SUB) || (i_cmd.op == OP_SLT);   // +1 for two's compl
            cause_q <= CAUSE_NONE;
         end else if (i_init || i_run) begin
            carry_q <= carry_out;
         end
         if (i_init && (op_q == OP_SLL) && (i_cnt < 5'd5)) begin
            shamt_q[i_cnt[2:0]] <= opb_q[0];
         end
         if (i_init && i_cnt_done) begin
            slt_q <= a_bit ^ b_bit ^ carry_out;   // sign corrected for overflow
         end
         if (i_trap) begin
            cause_q <= (op_q == OP_BRK) ? CAUSE_BREAK : CAUSE_ILLEGAL;
         end
      end
   end

   always_comb begin
      o_res.tag   = tag_q;
      o_res.cause = cause_q;
      o_res.value = res_q;
   end

endmodule

`default_nettype wire

/* verilog/serial_alu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module serial_alu_top (
   input  wire logic        i_clk,
   input  wire logic        i_rst,
   input  wire logic        i_psel,
   input  wire logic        i_penable,
   input  wire logic        i_pwrite,
   input  wire logic [7:0]  i_paddr,
   input  wire logic [31:0] i_pwdata,
   output logic      [31:0] o_prdata,
   output logic             o_pready,
   output logic             o_pslverr
);
   import serial_alu_pkg::*;

   cmd_t       cmd_wr;
   cmd_t       cmd_head;
   logic       cmd_push;
   logic       cmd_pop;
   logic       cmd_valid;
   logic       cmd_full;
   result_t    res_new;
   result_t    res_head;
   logic       res_push;
   logic       res_pop;
   logic       res_valid;
   logic       res_full;
   logic [2:0] res_count;
   logic       seq_load;
   logic       seq_init;
   logic       seq_run;
   logic       seq_trap;
   logic [4:0] seq_cnt;
   logic       seq_cnt_done;
   logic       seq_stage_two;

   // ------------------------------------------------------------------------
   // host side
   // ------------------------------------------------------------------------
   apb_cmd_port apb_cmd_port_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_psel      (i_psel),
      .i_penable   (i_penable),
      .i_pwrite    (i_pwrite),
      .i_paddr     (i_paddr),
      .i_pwdata    (i_pwdata),
      .o_prdata    (o_prdata),
      .o_pready    (o_pready),
      .o_pslverr   (o_pslverr),
      .i_cmd_full  (cmd_full),
      .i_res_valid (res_valid),
      .i_res       (res_head),
      .i_res_count (res_count),
      .o_cmd_push  (cmd_push),
      .o_cmd       (cmd_wr),
      .o_res_pop   (res_pop)
   );

   sync_fifo #(.WIDTH($bits(cmd_t))) cmd_fifo_i (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_push  (cmd_push),
      .i_data  (cmd_wr),
      .i_ready (cmd_pop),
      .o_data  (cmd_head),
      .o_valid (cmd_valid),
      .o_full  (cmd_full),
      .o_count ()                           // occupancy not needed here
   );

   sync_fifo #(.WIDTH($bits(result_t))) res_fifo_i (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_push  (res_push),
      .i_data  (res_new),
      .i_ready (res_pop),
      .o_data  (res_head),
      .o_valid (res_valid),
      .o_full  (res_full),
      .o_count (res_count)
   );

   // ------------------------------------------------------------------------
   // execution side
   // ------------------------------------------------------------------------
   serial_sequencer serial_sequencer_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_cmd_valid (cmd_valid),
      .i_cmd       (cmd_head),
      .i_res_full  (res_full),
      .o_cmd_ready (cmd_pop),
      .o_load      (seq_load),
      .o_op        (),                      // decoded op, debug visibility only
      .o_init      (seq_init),
      .o_run       (seq_run),
      .o_trap      (seq_trap),
      .o_cnt       (seq_cnt),
      .o_cnt_done  (seq_cnt_done),
      .o_stage_two (seq_stage_two)
   );

   serial_datapath serial_datapath_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_load      (seq_load),
      .i_cmd       (cmd_head),              // head is still valid on the pop cycle
      .i_init      (seq_init),
      .i_run       (seq_run),
      .i_trap      (seq_trap),
      .i_cnt       (seq_cnt),
      .i_cnt_done  (seq_cnt_done),
      .i_stage_two (seq_stage_two),
      .o_res_valid (res_push),
      .o_res       (res_new)
   );

endmodule

`default_nettype wire

/* verification/serial_alu_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module serial_alu_assert (
   input wire logic       i_clk,
   input wire logic       i_rst,
   input wire logic       i_pready,
   input wire logic       i_cmd_full,
   input wire logic       i_cmd_pop,
   input wire logic       i_res_full,
   input wire logic [2:0] i_res_count,
   input wire logic       i_res_push
);

   pready_high: assert property (@(posedge i_clk) disable iff (i_rst) i_pready)
      else $error("pready dropped low");

   // a count above depth would make full fall without a pop
   cmd_full_holds: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_cmd_full && !i_cmd_pop) |=> i_cmd_full)
      else $error("command queue left full state without a pop");

   res_full_no_grow: assert property (@(posedge i_clk) disable iff (i_rst)
      i_res_full |=> (i_res_count <= $past(i_res_count)))
      else $error("result queue count grew while full");

   res_push_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
      i_res_push |=> !i_res_push)
      else $error("result valid held longer than one cycle");

endmodule

bind serial_alu_top serial_alu_assert assert_i (
   .i_clk       (i_clk),
   .i_rst       (i_rst),
   .i_pready    (o_pready),
   .i_cmd_full  (cmd_full),
   .i_cmd_pop   (cmd_pop),
   .i_res_full  (res_full),
   .i_res_count (res_count),
   .i_res_push  (res_push)
);

`default_nettype wire

/* verification/serial_alu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "serial_alu_macros.svh"

module serial_alu_tb;
   import serial_alu_pkg::*;

   // 46 commands at most 80 cycles each plus reset and the empty-read checks
   localparam int CMD_COUNT      = 46;
   localparam int CYCLES_PER_CMD = 80;
   localparam int TIMEOUT_CYCLES = CMD_COUNT * CYCLES_PER_CMD + 320;

   logic        clk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [31:0] rng_state;
   logic [3:0]  next_tag;
   int          cycle_count = 0;

   serial_alu_top dut_i (
      .i_clk     (clk),
      .i_rst     (rst),
      .i_psel    (psel),
      .i_penable (penable),
      .i_pwrite  (pwrite),
      .i_paddr   (paddr),
      .i_pwdata  (pwdata),
      .o_prdata  (prdata),
      .o_pready  (pready),
      .o_pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                // 4 ns period
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         abort_run($sformatf("timeout: tests did not finish within %0d cycles",
                             TIMEOUT_CYCLES));
      end
   end

   // ------------------------------------------------------------------------
   // failure reporting and compare tasks
   // ------------------------------------------------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp) begin
         abort_run($sformatf("CHECK FAILED at %0t: %s expected 0x%08h got 0x%08h",
                             $time, name, exp, act));
      end
   endtask

   task automatic check_cause(input string name, input cause_e exp, input cause_e act);
      if (act !== exp) begin
         abort_run($sformatf("CHECK FAILED at %0t: %s expected %0d got %0d",
                             $time, name, exp, act));
      end
   endtask

   task automatic check_tag(input string name, input logic [3:0] exp,
                            input logic [3:0] act);
      if (act !== exp) begin
         abort_run($sformatf("CHECK FAILED at %0t: %s expected %0d got %0d",
                             $time, name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("CHECK FAILED at %0t: %s expected %0b got %0b",
                             $time, name, exp, act));
      end
   endtask

   // ------------------------------------------------------------------------
   // reference model and random source
   // ------------------------------------------------------------------------
   function automatic logic [31:0] xorshift_next();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [31:0] expected_value(input op_e op, input logic [31:0] a,
                                                  input logic [31:0] b);
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         OP_SLL:  return a << b[4:0];       // upper bits of b ignored
         default: return 32'd0;             // traps carry no value
      endcase
   endfunction

   function automatic cause_e expected_cause(input op_e op);
      case (op)
         OP_ADD, OP_SUB, OP_SLT, OP_SLL: return CAUSE_NONE;
         OP_BRK:  return CAUSE_BREAK;
         default: return CAUSE_ILLEGAL;
      endcase
   endfunction

   // ------------------------------------------------------------------------
   // APB transfers
   // ------------------------------------------------------------------------
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic err);
      @(negedge clk);
      psel    = 1'b1;                       // setup phase
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      #1;
      check_flag("pready (write)", 1'b1, pready);
      err = pslverr;                        // mid access phase
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      #1;
      check_flag("pready (read)", 1'b1, pready);
      data = prdata;
      err  = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic issue_cmd(input op_e op, input logic [3:0] tag, input logic [31:0] a,
                            input logic [31:0] b, output logic cmd_err);
      logic err;
      apb_write(`SA_REG_OPA, a, err);
      check_flag("pslverr (OPA write)", 1'b0, err);
      apb_write(`SA_REG_OPB, b, err);
      check_flag("pslverr (OPB write)", 1'b0, err);
      apb_write(`SA_REG_CMD, {24'd0, tag, 1'b0, op}, cmd_err);
   endtask

   // polls STATUS until enough results wait
   task automatic wait_results(input logic [2:0] n);
      logic [31:0] status;
      logic        err;
      status = '0;
      while (status[10:8] < n) begin
         apb_read(`SA_REG_STATUS, status, err);
      end
   endtask

   task automatic read_result(input logic [31:0] exp_val, input cause_e exp_cause,
                              input logic [3:0] exp_tag);
      logic [31:0] rdata;
      logic        err;
      apb_read(`SA_REG_RVAL, rdata, err);
      check_flag("pslverr (RVAL read)", 1'b0, err);
      check_value("rval", exp_val, rdata);
      apb_read(`SA_REG_RINFO, rdata, err);   // pops the head
      check_flag("pslverr (RINFO read)", 1'b0, err);
      check_tag("rinfo.tag", exp_tag, rdata[3:0]);
      check_cause("rinfo.cause", exp_cause, cause_e'(rdata[7:4]));
   endtask

   task automatic run_cmd(input op_e op, input logic [31:0] a, input logic [31:0] b);
      logic err;
      issue_cmd(op, next_tag, a, b, err);
      check_flag("pslverr (CMD write)", 1'b0, err);
      wait_results(3'd1);
      read_result(expected_value(op, a, b), expected_cause(op), next_tag);
      next_tag = next_tag + 4'd1;
   endtask

   // ------------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------------
   task automatic test_add_sub();
      logic [31:0] a;
      logic [31:0] b;
      for (int i = 0; i < 10; i++) begin
         a = xorshift_next();
         b = xorshift_next();
         run_cmd(OP_ADD, a, b);
         run_cmd(OP_SUB, a, b);
      end
   endtask

   task automatic test_slt();
      run_cmd(OP_SLT, 32'h1234_5678, 32'h1234_5678);   // equal
      run_cmd(OP_SLT, 32'h8000_0000, 32'd1);           // most negative vs +1
      run_cmd(OP_SLT, 32'd1, 32'h8000_0000);
      run_cmd(OP_SLT, 32'h7FFF_FFFF, 32'h8000_0000);   // subtract overflows
      for (int i = 0; i < 3; i++) begin
         run_cmd(OP_SLT, xorshift_next(), xorshift_next());
      end
   endtask

   task automatic test_sll();
      run_cmd(OP_SLL, xorshift_next(), 32'd0);
      run_cmd(OP_SLL, xorshift_next(), 32'd1);
      run_cmd(OP_SLL, xorshift_next(), 32'd31);
      run_cmd(OP_SLL, xorshift_next(), 32'hFFFF_FFE3);
      for (int i = 0; i < 3; i++) begin
         run_cmd(OP_SLL, xorshift_next(), xorshift_next());
      end
   endtask

   task automatic test_traps();
      run_cmd(OP_BRK, xorshift_next(), xorshift_next());
      run_cmd(op_e'(3'd5), xorshift_next(), xorshift_next());
      run_cmd(op_e'(3'd7), xorshift_next(), xorshift_next());
   endtask

   task automatic test_backpressure();
      logic [31:0] exp_vals [$];
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] status;
      logic [3:0]  tag;
      logic        err;
      tag = 4'd0;
      for (int i = 0; i < 4; i++) begin
         a = xorshift_next();
         b = xorshift_next();
         issue_cmd(OP_SLT, tag, a, b, err);
         check_flag("pslverr (CMD write)", 1'b0, err);
         exp_vals.push_back(expected_value(OP_SLT, a, b));
         tag = tag + 4'd1;
      end
      wait_results(3'd4);                   // result queue now full
      err = 1'b0;
      while (!err) begin
         if (tag == 4'd12) begin
            abort_run("command queue never refused a CMD write while results were held");
         end
         a = xorshift_next();
         b = xorshift_next();
         issue_cmd(OP_SLT, tag, a, b, err);
         if (!err) begin
            exp_vals.push_back(expected_value(OP_SLT, a, b));
            tag = tag + 4'd1;
         end
      end
      apb_read(`SA_REG_STATUS, status, err);
      check_flag("status.cmd_full", 1'b1, status[0]);
      for (int i = 0; i < exp_vals.size(); i++) begin
         wait_results(3'd1);
         read_result(exp_vals[i], CAUSE_NONE, 4'(i));   // tag order
      end
   endtask

   task automatic test_empty_reads();
      logic [31:0] rdata;
      logic        err;
      apb_read(`SA_REG_RINFO, rdata, err);
      check_flag("pslverr (empty RINFO)", 1'b1, err);
      check_value("rinfo (empty)", 32'd0, rdata);
      apb_read(`SA_REG_RVAL, rdata, err);
      check_flag("pslverr (empty RVAL)", 1'b1, err);
      check_value("rval (empty)", 32'd0, rdata);
      apb_read(`SA_REG_STATUS, rdata, err);
      check_value("status.res_count", 32'd0, {29'd0, rdata[10:8]});
   endtask

   initial begin
      rst       = 1'b1;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = 8'd0;
      pwdata    = 32'd0;
      rng_state = 32'd56803;
      next_tag  = 4'd0;
      repeat (4) @(negedge clk);
      rst = 1'b0;

      test_add_sub();
      test_slt();
      test_sll();
      test_traps();
      test_backpressure();
      test_empty_reads();

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/serial_alu_pkg.sv
verilog/sync_fifo.sv
verilog/apb_cmd_port.sv
verilog/serial_sequencer.sv
verilog/serial_datapath.sv
verilog/serial_alu_top.sv
verification/serial_alu_assert.sv
verification/serial_alu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the serial ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module serial_alu_tb \
   --Mdir obj_dir -o serial_alu_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/serial_alu_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
exit 0
